// File: source/csr_pkg.sv
// Shared types and constants for the machine-mode CSR unit
// Imported by the CSR register block, the trap controller and the top level

package csr_pkg;

  // Data widths with a meaning of their own
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] pc_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0]  csr_op_t;
  typedef logic [31:0] imm_t;
  typedef logic [63:0] counter_t;
  typedef logic [31:0] mcause_t;

  // funct3 codes, 0 means no write
  localparam csr_op_t CSR_OP_RW  = 3'd1;
  localparam csr_op_t CSR_OP_RS  = 3'd2;
  localparam csr_op_t CSR_OP_RC  = 3'd3;
  localparam csr_op_t CSR_OP_RWI = 3'd5;
  localparam csr_op_t CSR_OP_RSI = 3'd6;
  localparam csr_op_t CSR_OP_RCI = 3'd7;

  // Standard CSR addresses
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MISA     = 12'h301;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;
  localparam csr_addr_t CSR_MIP      = 12'h344;
  localparam csr_addr_t CSR_CYCLE    = 12'hC00;
  localparam csr_addr_t CSR_CYCLEH   = 12'hC80;
  localparam csr_addr_t CSR_MHARTID  = 12'hF14;

  // Bit positions in mstatus and in mie/mip
  localparam int MST_MIE  = 3;
  localparam int MST_MPIE = 7;
  localparam int IRQ_MSI  = 3;
  localparam int IRQ_MTI  = 7;
  localparam int IRQ_MEI  = 11;

  // mcause values, bit 31 marks an interrupt
  localparam mcause_t CAUSE_FETCH   = 32'd0;
  localparam mcause_t CAUSE_ILLEGAL = 32'd2;
  localparam mcause_t CAUSE_BREAK   = 32'd3;
  localparam mcause_t CAUSE_ECALL   = 32'd11;
  localparam mcause_t CAUSE_MSI     = 32'h8000_0003;
  localparam mcause_t CAUSE_MTI     = 32'h8000_0007;
  localparam mcause_t CAUSE_MEI     = 32'h8000_000B;

  // Software-writable bits per register
  localparam xlen_t MSTATUS_WMASK = ~32'h7FC0_0644;
  localparam xlen_t MIE_WMASK     = 32'h0000_0888;
  localparam xlen_t MTVEC_WMASK   = 32'hFFFF_FFFD;
  localparam xlen_t MEPC_WMASK    = 32'hFFFF_FFFC;
  localparam xlen_t MIP_WMASK     = 32'h0000_0008;

  // MPP fixed to machine mode, MPIE set
  localparam xlen_t MSTATUS_RST = 32'h0000_1880;

  // RV32I only, single hart
  localparam xlen_t MISA_VAL = 32'h4000_0100;
  localparam xlen_t HART_ID  = 32'h0000_0000;

  // Vectored-mode offsets from the mtvec base
  localparam xlen_t VEC_OFS_MSI = 32'h0000_000C;
  localparam xlen_t VEC_OFS_MTI = 32'h0000_001C;
  localparam xlen_t VEC_OFS_MEI = 32'h0000_002C;

endpackage

// File: source/csr_regs.sv
// Machine-mode CSR storage with a combinational read port
// Software writes land on the next edge unless stalled; trap updates take priority

`timescale 1ns/100ps

module csr_regs
  import csr_pkg::*;
#(
  parameter xlen_t MTVEC_DEFAULT_VAL = 32'h0000_1000
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      stall_i,
  input  csr_op_t   csr_op_i,
  input  csr_addr_t csr_addr_i,
  input  xlen_t     rs1_data_i,
  input  imm_t      imm_i,
  input  logic      trap_enter_i,
  input  logic      trap_return_i,
  input  mcause_t   trap_cause_i,
  input  pc_t       trap_epc_i,
  input  xlen_t     trap_tval_i,
  output xlen_t     csr_rd_o,
  output logic      mstatus_mie_o,
  output xlen_t     mie_o,
  output xlen_t     mtvec_o,
  output pc_t       mepc_o
);

  xlen_t    mstatus_q, mstatus_d;
  xlen_t    mie_q, mie_d;
  xlen_t    mtvec_q, mtvec_d;
  xlen_t    mscratch_q, mscratch_d;
  pc_t      mepc_q, mepc_d;
  mcause_t  mcause_q, mcause_d;
  xlen_t    mtval_q, mtval_d;
  xlen_t    mip_q, mip_d;
  counter_t cycle_q, cycle_d;

  xlen_t wr_src;
  logic  wr_en;

  // Bits outside the mask keep their old value
  function automatic xlen_t wr_csr_val(csr_op_t op, xlen_t src, xlen_t old, xlen_t mask);
    xlen_t val;
    case (op)
      CSR_OP_RW, CSR_OP_RWI: val = src;
      CSR_OP_RS, CSR_OP_RSI: val = old | src;
      CSR_OP_RC, CSR_OP_RCI: val = old & ~src;
      default:               val = old;
    endcase
    return (val & mask) | (old & ~mask);
  endfunction

  // funct3 bit 2 selects the immediate form
  assign wr_src = csr_op_i[2] ? xlen_t'(imm_i) : rs1_data_i;
  assign wr_en  = (csr_op_i != '0) && !stall_i;

  always_comb begin : rd_mux
    case (csr_addr_i)
      CSR_MSTATUS:  csr_rd_o = mstatus_q;
      CSR_MISA:     csr_rd_o = MISA_VAL;
      CSR_MIE:      csr_rd_o = mie_q;
      CSR_MTVEC:    csr_rd_o = mtvec_q;
      CSR_MSCRATCH: csr_rd_o = mscratch_q;
      CSR_MEPC:     csr_rd_o = mepc_q;
      CSR_MCAUSE:   csr_rd_o = mcause_q;
      CSR_MTVAL:    csr_rd_o = mtval_q;
      CSR_MIP:      csr_rd_o = mip_q;
      CSR_CYCLE:    csr_rd_o = cycle_q[31:0];
      CSR_CYCLEH:   csr_rd_o = cycle_q[63:32];
      CSR_MHARTID:  csr_rd_o = HART_ID;
      default:      csr_rd_o = '0;
    endcase
  end

  always_comb begin : next_state
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mtvec_d    = mtvec_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mip_d      = mip_q;
    // Free running, not affected by stall
    cycle_d    = cycle_q + counter_t'(1);

    if (wr_en) begin
      case (csr_addr_i)
        CSR_MSTATUS:  mstatus_d  = wr_csr_val(csr_op_i, wr_src, mstatus_q, MSTATUS_WMASK);
        CSR_MIE:      mie_d      = wr_csr_val(csr_op_i, wr_src, mie_q, MIE_WMASK);
        CSR_MTVEC:    mtvec_d    = wr_csr_val(csr_op_i, wr_src, mtvec_q, MTVEC_WMASK);
        CSR_MSCRATCH: mscratch_d = wr_csr_val(csr_op_i, wr_src, mscratch_q, '1);
        CSR_MEPC:     mepc_d     = wr_csr_val(csr_op_i, wr_src, mepc_q, MEPC_WMASK);
        CSR_MTVAL:    mtval_d    = wr_csr_val(csr_op_i, wr_src, mtval_q, '1);
        CSR_MIP:      mip_d      = wr_csr_val(csr_op_i, wr_src, mip_q, MIP_WMASK);
        default: begin
        end
      endcase
    end

    // Trap side effects override any software write in the same cycle
    if (trap_enter_i) begin
      mepc_d   = trap_epc_i & MEPC_WMASK;
      mcause_d = trap_cause_i;
      mtval_d  = trap_tval_i;
      case (trap_cause_i)
        CAUSE_MSI: mip_d[IRQ_MSI] = 1'b1;
        CAUSE_MTI: mip_d[IRQ_MTI] = 1'b1;
        CAUSE_MEI: mip_d[IRQ_MEI] = 1'b1;
        default: begin
        end
      endcase
      // Push the enable stack
      mstatus_d[MST_MPIE] = mstatus_q[MST_MIE];
      mstatus_d[MST_MIE]  = 1'b0;
    end else if (trap_return_i) begin
      // Pop the enable stack
      mstatus_d[MST_MIE]  = mstatus_q[MST_MPIE];
      mstatus_d[MST_MPIE] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_q  <= MSTATUS_RST;
      mie_q      <= '0;
      mtvec_q    <= MTVEC_DEFAULT_VAL;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= '0;
      cycle_q    <= '0;
    end else begin
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      mtvec_q    <= mtvec_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
      mip_q      <= mip_d;
      cycle_q    <= cycle_d;
    end
  end

  // State the trap controller needs
  assign mstatus_mie_o = mstatus_q[MST_MIE];
  assign mie_o         = mie_q;
  assign mtvec_o       = mtvec_q;
  assign mepc_o        = mepc_q;

endmodule

// File: source/trap_ctrl.sv
// Trap controller: picks the highest priority trap source each cycle
// Hands cause, epc and tval to the register block and emits a one-cycle trap pulse

`timescale 1ns/100ps

module trap_ctrl
  import csr_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n_i,
  input  pc_t     pc_addr_i,
  input  logic    ext_irq_i,
  input  logic    sw_irq_i,
  input  logic    timer_irq_i,
  input  logic    will_jump_i,
  input  logic    dec_trap_i,
  input  pc_t     dec_trap_pc_i,
  input  xlen_t   dec_trap_mtval_i,
  input  logic    fetch_trap_i,
  input  xlen_t   fetch_trap_mtval_i,
  input  logic    ecall_i,
  input  logic    ebreak_i,
  input  logic    mret_i,
  input  logic    mstatus_mie_i,
  input  xlen_t   mie_i,
  input  xlen_t   mtvec_i,
  input  pc_t     mepc_i,
  output logic    trap_enter_o,
  output logic    trap_return_o,
  output mcause_t trap_cause_o,
  output pc_t     trap_epc_o,
  output xlen_t   trap_tval_o,
  output logic    trap_o,
  output pc_t     trap_pc_o
);

  logic  take_mei;
  logic  take_msi;
  logic  take_mti;
  logic  take_dec;
  logic  trap_fire;
  pc_t   mtvec_base;
  xlen_t vec_ofs;
  pc_t   target_pc;

  // Interrupts only when globally and individually enabled
  assign take_mei = mstatus_mie_i & ext_irq_i & mie_i[IRQ_MEI];
  assign take_msi = mstatus_mie_i & sw_irq_i & mie_i[IRQ_MSI];
  assign take_mti = mstatus_mie_i & timer_irq_i & mie_i[IRQ_MTI];
  // Decode trap on a wrong-path instruction is dropped
  assign take_dec = dec_trap_i & ~will_jump_i;

  always_comb begin : trap_sel
    trap_enter_o  = 1'b1;
    trap_return_o = 1'b0;
    trap_cause_o  = '0;
    trap_epc_o    = pc_addr_i;
    trap_tval_o   = '0;
    if (take_mei) begin
      trap_cause_o = CAUSE_MEI;
    end else if (take_msi) begin
      trap_cause_o = CAUSE_MSI;
    end else if (take_mti) begin
      trap_cause_o = CAUSE_MTI;
    end else if (take_dec) begin
      trap_cause_o = CAUSE_ILLEGAL;
      trap_epc_o   = dec_trap_pc_i;
      trap_tval_o  = dec_trap_mtval_i;
    end else if (fetch_trap_i) begin
      trap_cause_o = CAUSE_FETCH;
      trap_tval_o  = fetch_trap_mtval_i;
    end else if (ecall_i) begin
      trap_cause_o = CAUSE_ECALL;
    end else if (ebreak_i) begin
      trap_cause_o = CAUSE_BREAK;
    end else begin
      // mret is lowest priority and is not a trap entry
      trap_enter_o  = 1'b0;
      trap_return_o = mret_i;
    end
  end

  assign mtvec_base = {mtvec_i[31:2], 2'b00};

  // Offset only for interrupts in vectored mode
  always_comb begin : vec_sel
    vec_ofs = '0;
    if (mtvec_i[0]) begin
      case (trap_cause_o)
        CAUSE_MSI: vec_ofs = VEC_OFS_MSI;
        CAUSE_MTI: vec_ofs = VEC_OFS_MTI;
        CAUSE_MEI: vec_ofs = VEC_OFS_MEI;
        default:   vec_ofs = '0;
      endcase
    end
  end

  assign target_pc = trap_return_o ? mepc_i : mtvec_base + vec_ofs;
  assign trap_fire = trap_enter_o | trap_return_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trap_o    <= 1'b0;
      trap_pc_o <= '0;
    end else begin
      trap_o    <= trap_fire;
      trap_pc_o <= trap_fire ? target_pc : '0;
    end
  end

endmodule

// File: source/csr_unit.sv
// Top level of the machine-mode CSR unit
// Joins the CSR register block and the trap controller; mtvec reset value is set here

`timescale 1ns/100ps

module csr_unit
  import csr_pkg::*;
#(
  parameter xlen_t MTVEC_DEFAULT_VAL = 32'h0000_1000
) (
  input  logic      clk,
  input  logic      rst_n_i,
  // CSR access from execute
  input  csr_op_t   csr_op_i,
  input  csr_addr_t csr_addr_i,
  input  xlen_t     rs1_data_i,
  input  imm_t      imm_i,
  input  logic      stall_i,
  // Trap sources
  input  pc_t       pc_addr_i,
  input  logic      ext_irq_i,
  input  logic      sw_irq_i,
  input  logic      timer_irq_i,
  input  logic      will_jump_i,
  input  logic      dec_trap_i,
  input  pc_t       dec_trap_pc_i,
  input  xlen_t     dec_trap_mtval_i,
  input  logic      fetch_trap_i,
  input  xlen_t     fetch_trap_mtval_i,
  input  logic      ecall_i,
  input  logic      ebreak_i,
  input  logic      mret_i,
  output xlen_t     csr_rd_o,
  output logic      trap_o,
  output pc_t       trap_pc_o
);

  logic    mstatus_mie;
  xlen_t   mie;
  xlen_t   mtvec;
  pc_t     mepc;
  logic    trap_enter;
  logic    trap_return;
  mcause_t trap_cause;
  pc_t     trap_epc;
  xlen_t   trap_tval;

  csr_regs #(
    .MTVEC_DEFAULT_VAL(MTVEC_DEFAULT_VAL)
  ) u_csr_regs (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .csr_op_i      (csr_op_i),
    .csr_addr_i    (csr_addr_i),
    .rs1_data_i    (rs1_data_i),
    .imm_i         (imm_i),
    .trap_enter_i  (trap_enter),
    .trap_return_i (trap_return),
    .trap_cause_i  (trap_cause),
    .trap_epc_i    (trap_epc),
    .trap_tval_i   (trap_tval),
    .csr_rd_o      (csr_rd_o),
    .mstatus_mie_o (mstatus_mie),
    .mie_o         (mie),
    .mtvec_o       (mtvec),
    .mepc_o        (mepc)
  );

  trap_ctrl u_trap_ctrl (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .pc_addr_i          (pc_addr_i),
    .ext_irq_i          (ext_irq_i),
    .sw_irq_i           (sw_irq_i),
    .timer_irq_i        (timer_irq_i),
    .will_jump_i        (will_jump_i),
    .dec_trap_i         (dec_trap_i),
    .dec_trap_pc_i      (dec_trap_pc_i),
    .dec_trap_mtval_i   (dec_trap_mtval_i),
    .fetch_trap_i       (fetch_trap_i),
    .fetch_trap_mtval_i (fetch_trap_mtval_i),
    .ecall_i            (ecall_i),
    .ebreak_i           (ebreak_i),
    .mret_i             (mret_i),
    .mstatus_mie_i      (mstatus_mie),
    .mie_i              (mie),
    .mtvec_i            (mtvec),
    .mepc_i             (mepc),
    .trap_enter_o       (trap_enter),
    .trap_return_o      (trap_return),
    .trap_cause_o       (trap_cause),
    .trap_epc_o         (trap_epc),
    .trap_tval_o        (trap_tval),
    .trap_o             (trap_o),
    .trap_pc_o          (trap_pc_o)
  );

endmodule

// File: test/csr_checker.sv
// Watches the CSR unit outputs and compares them with the expected pattern columns
// Read data is compared at each rising edge, trap outputs one cycle after their row

`timescale 1ns/100ps

module csr_checker
  import csr_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  chk_en_i,
  input  xlen_t exp_rd_i,
  input  logic  exp_trap_i,
  input  pc_t   exp_trap_pc_i,
  input  xlen_t csr_rd_i,
  input  logic  trap_i,
  input  pc_t   trap_pc_i,
  output int    err_cnt_o,
  output int    row_cnt_o
);

  logic prev_en = 1'b0;
  logic prev_trap = 1'b0;
  pc_t  prev_trap_pc = '0;
  int   errs = 0;

  initial begin
    err_cnt_o = 0;
    row_cnt_o = 0;
  end

  always @(posedge clk) begin
    if (rst_n_i) begin
      // Combinational read still shows the state before this edge
      if (chk_en_i && csr_rd_i !== exp_rd_i) begin
        $display("Error at %0t: csr_rd_o expected %h, got %h", $time, exp_rd_i, csr_rd_i);
        errs = errs + 1;
      end
      // Trap outputs from the previous row's edge
      if (prev_en) begin
        if (trap_i !== prev_trap) begin
          $display("Error at %0t: trap_o expected %b, got %b", $time, prev_trap, trap_i);
          errs = errs + 1;
        end else if (prev_trap && trap_pc_i !== prev_trap_pc) begin
          $display("Error at %0t: trap_pc_o expected %h, got %h", $time, prev_trap_pc,
                   trap_pc_i);
          errs = errs + 1;
        end
        row_cnt_o <= row_cnt_o + 1;
      end
      prev_en      <= chk_en_i;
      prev_trap    <= exp_trap_i;
      prev_trap_pc <= exp_trap_pc_i;
      err_cnt_o    <= errs;
    end
  end

endmodule

// File: test/csr_unit_assert.sv
// Concurrent checks on trap timing, reset state and the read-only mcause
// Bound into every csr_unit instance

`timescale 1ns/100ps

module csr_unit_assert
  import csr_pkg::*;
(
  input logic      clk,
  input logic      rst_n_i,
  input logic      trap_i,
  input logic      trap_enter_i,
  input pc_t       trap_pc_i,
  input xlen_t     mtvec_i,
  input csr_op_t   csr_op_i,
  input csr_addr_t csr_addr_i,
  input mcause_t   mcause_i
);

  // Failure count for the closing result line
  int fail_cnt = 0;

  single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) trap_i |=> !trap_i)
    else begin
      fail_cnt++;
      $error("trap_o stayed high for two cycles");
    end

  quiet_in_reset: assert property (@(posedge clk) !rst_n_i |-> !trap_i)
    else begin
      fail_cnt++;
      $error("trap_o high during reset");
    end

  // Direct base and mepc are both word aligned
  aligned_target: assert property (@(posedge clk) disable iff (!rst_n_i)
    (trap_i && mtvec_i[1:0] == 2'b00) |-> trap_pc_i[1:0] == 2'b00)
    else begin
      fail_cnt++;
      $error("trap_pc_o not word aligned");
    end

  mcause_read_only: assert property (@(posedge clk) disable iff (!rst_n_i)
    (csr_op_i != 3'd0 && csr_addr_i == CSR_MCAUSE && !trap_enter_i) |=> $stable(mcause_i))
    else begin
      fail_cnt++;
      $error("mcause changed by a software write");
    end

endmodule

bind csr_unit csr_unit_assert u_csr_unit_assert (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .trap_i       (trap_o),
  .trap_enter_i (trap_enter),
  .trap_pc_i    (trap_pc_o),
  .mtvec_i      (mtvec),
  .csr_op_i     (csr_op_i),
  .csr_addr_i   (csr_addr_i),
  .mcause_i     (u_csr_regs.mcause_q)
);

// File: test/tb_csr_unit.sv
// Testbench for the CSR unit that applies one pattern row per cycle on the falling edge
// Rows come from test/csr_patterns.txt and csr_checker does the comparing

`timescale 1ns/100ps

module tb_csr_unit;
  import csr_pkg::*;

  localparam int ROW_MAX    = 64;
  localparam int ROW_WORDS  = 11;
  localparam int WAIT_LIMIT = 20;

  logic clk;
  logic rst_n_i;
  csr_op_t csr_op_i;
  csr_addr_t csr_addr_i;
  xlen_t rs1_data_i;
  imm_t imm_i;
  logic stall_i;
  pc_t pc_addr_i;
  logic ext_irq_i, sw_irq_i, timer_irq_i, will_jump_i;
  logic dec_trap_i, fetch_trap_i, ecall_i, ebreak_i, mret_i;
  pc_t dec_trap_pc_i;
  xlen_t dec_trap_mtval_i, fetch_trap_mtval_i;
  xlen_t csr_rd_o;
  logic trap_o;
  pc_t trap_pc_o;

  logic chk_en;
  xlen_t exp_rd;
  logic exp_trap;
  pc_t exp_trap_pc;
  int err_cnt, row_cnt, n_rows, wait_cyc;
  int assert_cnt;
  logic timed_out;
  logic [31:0] pat_mem [ROW_MAX*ROW_WORDS];

  csr_unit #(
    .MTVEC_DEFAULT_VAL(32'h0000_1000)
  ) u_csr_unit (
    .clk(clk), .rst_n_i(rst_n_i),
    .csr_op_i(csr_op_i), .csr_addr_i(csr_addr_i), .rs1_data_i(rs1_data_i),
    .imm_i(imm_i), .stall_i(stall_i), .pc_addr_i(pc_addr_i),
    .ext_irq_i(ext_irq_i), .sw_irq_i(sw_irq_i), .timer_irq_i(timer_irq_i),
    .will_jump_i(will_jump_i), .dec_trap_i(dec_trap_i), .dec_trap_pc_i(dec_trap_pc_i),
    .dec_trap_mtval_i(dec_trap_mtval_i), .fetch_trap_i(fetch_trap_i),
    .fetch_trap_mtval_i(fetch_trap_mtval_i), .ecall_i(ecall_i), .ebreak_i(ebreak_i),
    .mret_i(mret_i), .csr_rd_o(csr_rd_o), .trap_o(trap_o), .trap_pc_o(trap_pc_o)
  );

  csr_checker u_csr_checker (
    .clk(clk), .rst_n_i(rst_n_i), .chk_en_i(chk_en), .exp_rd_i(exp_rd),
    .exp_trap_i(exp_trap), .exp_trap_pc_i(exp_trap_pc), .csr_rd_i(csr_rd_o),
    .trap_i(trap_o), .trap_pc_i(trap_pc_o), .err_cnt_o(err_cnt), .row_cnt_o(row_cnt)
  );

  always #5 clk = ~clk;

  task automatic drive_idle();
    {csr_op_i, csr_addr_i, rs1_data_i, imm_i, stall_i, pc_addr_i} = '0;
    {ext_irq_i, sw_irq_i, timer_irq_i, will_jump_i} = '0;
    {dec_trap_i, fetch_trap_i, ecall_i, ebreak_i, mret_i} = '0;
    {dec_trap_pc_i, dec_trap_mtval_i, fetch_trap_mtval_i} = '0;
    {chk_en, exp_rd, exp_trap, exp_trap_pc} = '0;
  endtask

  // Word 0 holds address, op, stall and mret; word 1 one nibble per trap flag
  task automatic drive_row(int r);
    int b;
    b = r * ROW_WORDS;
    csr_addr_i         = pat_mem[b][31:20];
    csr_op_i           = pat_mem[b][18:16];
    stall_i            = pat_mem[b][12];
    mret_i             = pat_mem[b][0];
    ext_irq_i          = pat_mem[b+1][28];
    sw_irq_i           = pat_mem[b+1][24];
    timer_irq_i        = pat_mem[b+1][20];
    will_jump_i        = pat_mem[b+1][16];
    dec_trap_i         = pat_mem[b+1][12];
    fetch_trap_i       = pat_mem[b+1][8];
    ecall_i            = pat_mem[b+1][4];
    ebreak_i           = pat_mem[b+1][0];
    rs1_data_i         = pat_mem[b+2];
    imm_i              = pat_mem[b+3];
    pc_addr_i          = pat_mem[b+4];
    dec_trap_pc_i      = pat_mem[b+5];
    dec_trap_mtval_i   = pat_mem[b+6];
    fetch_trap_mtval_i = pat_mem[b+7];
    exp_rd             = pat_mem[b+8];
    exp_trap           = pat_mem[b+9][0];
    exp_trap_pc        = pat_mem[b+10];
    chk_en             = 1'b1;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n_i    = 1'b0;
    timed_out  = 1'b0;
    n_rows     = 0;
    wait_cyc   = 0;
    assert_cnt = 0;
    drive_idle();
    $readmemh("test/csr_patterns.txt", pat_mem);
    repeat (8) @(negedge clk);
    rst_n_i = 1'b1;
    // A row starting with all ones ends the table
    while (n_rows < ROW_MAX && pat_mem[n_rows*ROW_WORDS] != 32'hFFFF_FFFF) begin
      @(negedge clk);
      drive_row(n_rows);
      n_rows++;
    end
    @(negedge clk);
    drive_idle();
    while (row_cnt < n_rows && wait_cyc < WAIT_LIMIT) begin
      @(posedge clk);
      wait_cyc++;
    end
    if (row_cnt < n_rows) begin
      timed_out = 1'b1;
      $display("Timeout: checker finished %0d of %0d rows", row_cnt, n_rows);
    end
    assert_cnt = u_csr_unit.u_csr_unit_assert.fail_cnt;
    $display("Rows checked: %0d, errors: %0d, assertion failures: %0d", row_cnt, err_cnt,
             assert_cnt);
    if (timed_out || err_cnt != 0 || assert_cnt != 0 || n_rows == 0) begin
      $display("Result: FAILED");
    end else begin
      $display("Result: PASSED");
    end
    $finish;
  end

endmodule

// File: test/csr_patterns.txt
// ctrl(addr,op,stall,mret) flags(ext,sw,tmr,wj,dec,fetch,ecall,ebreak) rs1 imm pc
// dec_pc dec_mtval fetch_mtval exp_rd exp_trap exp_trap_pc
30000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00001880 00000000 00000000
30100000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 40000100 00000000 00000000
F1400000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
7FF00000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
34010000 00000000 12345678 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
34020000 00000000 0000FF00 00000000 00000000 00000000 00000000 00000000 12345678 00000000 00000000
34030000 00000000 000000F0 00000000 00000000 00000000 00000000 00000000 1234FF78 00000000 00000000
34050000 00000000 00000000 0000001F 00000000 00000000 00000000 00000000 1234FF08 00000000 00000000
34060000 00000000 00000000 00000020 00000000 00000000 00000000 00000000 0000001F 00000000 00000000
34070000 00000000 00000000 00000003 00000000 00000000 00000000 00000000 0000003F 00000000 00000000
34011000 00000000 AAAAAAAA 00000000 00000000 00000000 00000000 00000000 0000003C 00000000 00000000
34021000 00000000 FFFFFFFF 00000000 00000000 00000000 00000000 00000000 0000003C 00000000 00000000
C0001000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000000D 00000000 00000000
C0001000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000000E 00000000 00000000
30010000 00000000 FFFFFFFF 00000000 00000000 00000000 00000000 00000000 00001880 00000000 00000000
30410000 00000000 FFFFFFFF 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
34110000 00000000 FFFFFFFF 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
34410000 00000000 FFFFFFFF 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
34210000 00000000 12345678 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
30510000 00000000 00000201 00000000 00000000 00000000 00000000 00000000 00001000 00000000 00000000
30000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 803FF9BB 00000000 00000000
30400000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000888 00000000 00000000
34100000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FFFFFFFC 00000000 00000000
34400000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000008 00000000 00000000
34200000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
30500000 11100000 00000000 00000000 00000444 00000000 00000000 00000000 00000201 00000001 0000022C
34200000 11100000 00000000 00000000 00000448 00000000 00000000 00000000 8000000B 00000000 00000000
34100000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000444 00000000 00000000
30000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 803FF9B3 00000000 00000000
34400000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000808 00000000 00000000
34300001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000001 00000444
30000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 803FF9BB 00000000 00000000
34400000 00100000 00000000 00000000 00000600 00000000 00000000 00000000 00000808 00000001 0000021C
34200000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 80000007 00000000 00000000
34100001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000600 00000001 00000600
30000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 803FF9BB 00000000 00000000
30510000 00000000 00000300 00000000 00000000 00000000 00000000 00000000 00000201 00000000 00000000
30500000 01000000 00000000 00000000 00000700 00000000 00000000 00000000 00000300 00000001 00000300
34200000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 80000003 00000000 00000000
34100000 00011000 00000000 00000000 00000804 00000800 DEADBEEF 00000000 00000700 00000000 00000000
30000000 00001000 00000000 00000000 00000904 00000900 DEADBEEF 00000000 803FF9B3 00000001 00000300
34200000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000002 00000000 00000000
34300000 00000100 00000000 00000000 00000A00 00000000 00000000 CAFEF00D DEADBEEF 00000001 00000300
34100000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000A00 00000000 00000000
34300000 00000010 00000000 00000000 00000B00 00000000 00000000 00000000 CAFEF00D 00000001 00000300
34200000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000000B 00000000 00000000
34300000 00000001 00000000 00000000 00000C00 00000000 00000000 00000000 00000000 00000001 00000300
34200000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000003 00000000 00000000
34100001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000C00 00000001 00000C00
30000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 803FF9B3 00000000 00000000
// end of table
FFFFFFFF

// File: build.f
source/csr_pkg.sv
source/csr_regs.sv
source/trap_ctrl.sv
source/csr_unit.sv
test/csr_checker.sv
test/csr_unit_assert.sv
test/tb_csr_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_csr_unit -o sim_csr_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_csr_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
